// File: list.f
verilog/risc5_isa_pkg.sv
verilog/risc5_bus_pkg.sv
verilog/core_alu.sv
verilog/core_datapath.sv
verilog/core_ctrl.sv
verilog/risc5_core.sv
tb/core_asserts.sv
tb/core_monitor.sv
tb/tb_risc5_core.sv

// File: run_sim.sh
#!/bin/sh
# build the RISC5 core testbench with Verilator, run it, then check the log
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_risc5_core \
  -o sim_tb > build.log 2>&1 &&
./obj_dir/sim_tb > sim.log 2>&1 ||
{ echo "build or simulation run did not complete"; cat build.log sim.log; exit 1; }
cat sim.log
grep -q "Testbench passed" sim.log || exit 1

// File: tb/tb_risc5_core.sv
/*
  RISC5 core testbench: random program, memory with random ack delay,
  reference monitor and bound bus assertions
*/
`timescale 1ns/1ps

module tb_risc5_core import risc5_bus_pkg::*; ();

  localparam logic [addr_w-1:0] reset_addr = 24'h000100;
  localparam int                prog_len   = 137;
  localparam logic [addr_w-1:0] end_addr   = reset_addr + 24'(4 * (prog_len - 1));
  localparam int                base       = int'(reset_addr) / 4;

  logic              clk;
  logic              rst;
  bus_req_t          bus_req;
  logic [data_w-1:0] rdata;
  logic              ack;
  logic [31:0]       mem [4096];
  int                wait_cnt;
  logic              done;
  int                errors;
  int                cycles;

  risc5_core #(.reset_addr(reset_addr)) i_dut (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .rdata   (rdata),
    .ack     (ack)
  );

  core_monitor #(.reset_addr(reset_addr), .end_addr(end_addr)) i_monitor (
    .clk     (clk),
    .rst     (rst),
    .bus_req (bus_req),
    .rdata   (rdata),
    .ack     (ack),
    .done    (done),
    .errors  (errors)
  );

  bind risc5_core core_asserts i_asserts (
    .clk(clk), .rst(rst), .bus_req(bus_req), .ack(ack)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // instruction encoders
  function automatic logic [31:0] reg_reg_word(input int op, input int a, input int b,
                                               input int c);
    return {2'b00, 2'b00, 4'(a), 4'(b), 4'(op), 12'h000, 4'(c)};
  endfunction

  function automatic logic [31:0] reg_imm_word(input logic u, input logic v, input int op,
                                               input int a, input int b,
                                               input logic [15:0] imm);
    return {2'b01, u, v, 4'(a), 4'(b), 4'(op), imm};
  endfunction

  function automatic logic [31:0] memory_word(input logic u, input int a, input int b,
                                              input int off);
    return {2'b10, u, 1'b0, 4'(a), 4'(b), 20'(off)};
  endfunction

  function automatic logic [31:0] branch_word(input logic u, input logic v,
                                              input logic [3:0] cnd,
                                              input logic [23:0] dist_or_c);
    return {2'b11, u, v, cnd, dist_or_c};
  endfunction

  function automatic logic [31:0] fill_word(input int idx);
    return (32'(idx) * 32'h9e3779b1) ^ 32'h5a5a0000;  // whole word index
  endfunction

  // --------------------------------------------------
  // init all registers, set C and V, random body, branch-to-self at the end
  task automatic gen_program();
    int i;
    int pick;
    int d;
    int t;
    int reach;  // furthest branch target so far
    for (int k = 0; k < 4096; k++) mem[k] = fill_word(k);
    for (int r = 0; r < 16; r++) begin
      if (r == 13) mem[base + r] = reg_imm_word(1'b0, 1'b0, 0, r, 0, 16'h2000);  // data window
      else mem[base + r] = reg_imm_word(1'b0, 1'($urandom), 0, r, 0, 16'($urandom));
    end
    mem[base + 16] = reg_imm_word(1'b0, 1'b0, 8, 0, 0, 16'($urandom));
    i     = 17;
    reach = 0;
    while (i < prog_len - 1) begin
      pick = $urandom % 10;
      if (pick == 9 && i < prog_len - 3 && reach <= i) begin
        t = i + 2 + $urandom % 3;
        if (t > prog_len - 1) t = prog_len - 1;
        reach = t;
        mem[base + i]     = reg_imm_word(1'b0, 1'b0, 0, 14, 0, 16'(int'(reset_addr) + 4 * t));
        mem[base + i + 1] = branch_word(1'b0, 1'($urandom), 4'($urandom), 24'd14);
        i = i + 2;
      end else begin
        if (pick == 4) begin
          mem[base + i] = memory_word(1'b0, $urandom % 13, 13, 4 * ($urandom % 64));
        end else if (pick == 5 || pick == 6) begin
          mem[base + i] = memory_word(1'b1, $urandom % 16, 13, 4 * ($urandom % 64));
        end else if (pick == 7 || pick == 8) begin
          d = $urandom % 4;
          if (d > prog_len - 2 - i) d = prog_len - 2 - i;  // forward only
          if (i + 1 + d > reach) reach = i + 1 + d;
          mem[base + i] = branch_word(1'b1, 1'($urandom), 4'($urandom), 24'(d));
        end else if ($urandom % 2) begin
          mem[base + i] = reg_reg_word($urandom % 12, $urandom % 13, $urandom % 16,
                                       $urandom % 16);
        end else begin
          mem[base + i] = reg_imm_word(1'($urandom), 1'($urandom), $urandom % 12,
                                       $urandom % 13, $urandom % 16, 16'($urandom));
        end
        i = i + 1;
      end
    end
    mem[base + prog_len - 1] = branch_word(1'b1, 1'b0, 4'b0111, 24'hffffff);
  endtask

  // memory, ack after 0 to 3 falling edges
  always @(negedge clk) begin
    if (ack) begin
      ack = 1'b0;
    end else if (!rst && bus_req.stb) begin
      if (wait_cnt == 0) begin
        if (bus_req.we) mem[bus_req.addr[13:2]] = bus_req.wdata;
        else rdata = mem[bus_req.addr[13:2]];
        ack      = 1'b1;
        wait_cnt = $urandom % 4;
      end else begin
        wait_cnt = wait_cnt - 1;
      end
    end
  end

  initial begin
    rst   = 1'b1;
    ack   = 1'b0;
    rdata = '0;
    void'($urandom(14));
    wait_cnt = $urandom % 4;
    gen_program();
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst    = 1'b0;
    cycles = 0;
    while (!done && cycles < 20000) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) $display("timeout: the program end was never fetched");
    if (done && errors == 0 && i_dut.i_asserts.fail_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: tb/core_monitor.sv
/*
  RISC5 instruction-level reference model, follows the bus traffic of the
  core and checks fetch addresses, store data, load data and bus timing
*/
`timescale 1ns/1ps

module core_monitor import risc5_isa_pkg::*, risc5_bus_pkg::*; #(
  parameter logic [addr_w-1:0] reset_addr = '0,
  parameter logic [addr_w-1:0] end_addr   = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  bus_req_t          bus_req,
  input  logic [data_w-1:0] rdata,
  input  logic              ack,
  output logic              done,
  output int                errors
);

  logic [31:0]       regs [16];
  int                kind [16];  // test that covers the last write of each register
  flags_t            fl;
  logic [addr_w-1:0] pc;
  logic              first;
  logic              mem_pending;
  instr_t            cur;
  logic [addr_w-1:0] ea;
  logic [31:0]       stored [int];
  int                gap;
  int                exp_gap;
  logic              stb_q;
  logic              ack_q;
  int                checks [6];
  int                fails [6];
  string             names [6];

  initial begin
    names = '{"reset_vector", "alu_results", "branches", "link", "loads_stores",
              "bus_timing"};
    errors = 0;
    done   = 1'b0;
  end

  task automatic check(input int t, input logic [31:0] exp_v, input logic [31:0] act_v);
    checks[t]++;
    if (exp_v !== act_v) begin
      fails[t]++;
      errors++;
      $display("CHECK FAILED %s: expected %h, actual %h", names[t], exp_v, act_v);
    end
  endtask

  function automatic logic cond_true(input logic [3:0] a, input flags_t f);
    logic c;
    case (a[2:0])
      3'd0:    c = f.n;
      3'd1:    c = f.z;
      3'd2:    c = f.c;
      3'd3:    c = f.v;
      3'd4:    c = f.c | f.z;
      3'd5:    c = f.n ^ f.v;
      3'd6:    c = (f.n ^ f.v) | f.z;
      default: c = 1'b1;
    endcase
    return a[3] ^ c;  // a[3] inverts
  endfunction

  // --------------------------------------------------
  task automatic run_alu(input instr_t ins);
    logic [31:0] x;
    logic [31:0] y;
    logic [31:0] r;
    logic [4:0]  s;
    logic [32:0] wide;
    x = regs[ins.b];
    if (ins.pq == fmt_reg_reg) y = regs[ins.imm[3:0]];
    else if (ins.op == 4'h0 && ins.u) y = {ins.imm, 16'h0000};
    else y = {{16{ins.v}}, ins.imm};
    s    = y[4:0];
    wide = '0;
    case (ins.op)
      4'h0:    r = y;
      4'h1:    r = x << s;
      4'h2:    r = $signed(x) >>> s;
      4'h3:    r = (x >> s) | (x << (32 - int'(s)));
      4'h4:    r = x & y;
      4'h5:    r = x & ~y;
      4'h6:    r = x | y;
      4'h7:    r = x ^ y;
      4'h8: begin
        wide = {1'b0, x} + {1'b0, y};
        r    = wide[31:0];
      end
      4'h9: begin
        wide = {1'b0, x} - {1'b0, y};  // top bit is the borrow
        r    = wide[31:0];
      end
      default: r = '0;
    endcase
    if (ins.op <= 4'h9) begin
      fl.n = r[31];
      fl.z = (r == '0);
    end
    if (ins.op == 4'h8) begin
      fl.c = wide[32];
      fl.v = (x[31] == y[31]) && (r[31] != x[31]);
    end else if (ins.op == 4'h9) begin
      fl.c = wide[32];
      fl.v = (x[31] != y[31]) && (r[31] != x[31]);
    end
    regs[ins.a] = r;
    kind[ins.a] = 1;
  endtask

  task automatic report();
    for (int t = 1; t < 6; t++) begin
      $display("test %s: %0d checks, %0d failed", names[t], checks[t], fails[t]);
    end
    $display("all tests: %0d checks, %0d failed", checks.sum(), errors);
  endtask

  // --------------------------------------------------
  // one completed transfer per ack
  task automatic on_transfer();
    logic [addr_w-1:0] target;
    if (mem_pending) begin
      check(4, ea, bus_req.addr);
      check(4, cur.u, bus_req.we);
      if (cur.u) begin
        check(kind[cur.a], regs[cur.a], bus_req.wdata);
        stored[int'(ea)] = regs[cur.a];
        exp_gap = 0;
      end else begin
        if (stored.exists(int'(ea))) check(4, stored[int'(ea)], rdata);
        regs[cur.a] = rdata;
        kind[cur.a] = 4;
        exp_gap     = 1;
      end
      mem_pending = 1'b0;
      return;
    end
    if (first) begin
      check(0, reset_addr, bus_req.addr);
      $display("test reset_vector: %0d checks, %0d failed", checks[0], fails[0]);
      first = 1'b0;
    end else begin
      check(2, pc, bus_req.addr);
    end
    if (pc == end_addr) begin
      report();
      done = 1'b1;
    end
    pc  = pc + 4;
    cur = instr_t'(rdata);
    case (cur.pq)
      fmt_reg_reg, fmt_reg_imm: begin
        run_alu(cur);
        exp_gap = 3;
      end
      fmt_memory: begin
        ea          = regs[cur.b][addr_w-1:0] + {{4{rdata[19]}}, rdata[19:0]};
        mem_pending = 1'b1;
        exp_gap     = 2;
      end
      default: begin
        exp_gap = 2;
        if (cond_true(cur.a, fl)) begin
          target = cur.u ? pc + {rdata[21:0], 2'b00} : regs[cur.imm[3:0]][addr_w-1:0];
          if (cur.v) begin
            regs[link_reg] = {8'h00, pc};  // return address
            kind[link_reg] = 3;
          end
          pc = target;
        end
      end
    endcase
  endtask

  always @(posedge clk) begin
    if (rst) begin
      first       = 1'b1;
      mem_pending = 1'b0;
      pc          = reset_addr;
      gap         = 0;
      exp_gap     = -1;
      stb_q       = 1'b0;
      ack_q       = 1'b0;
    end else begin
      if (bus_req.stb && (!stb_q || ack_q) && exp_gap >= 0) check(5, exp_gap, gap);
      if (!bus_req.stb) gap = gap + 1;
      if (bus_req.stb && ack) begin
        gap = 0;
        on_transfer();
      end
      stb_q = bus_req.stb;
      ack_q = ack;
    end
  end

endmodule

// File: tb/core_asserts.sv
/*
  RISC5 bus protocol assertions, bound to the core top
*/
`timescale 1ns/1ps

module core_asserts import risc5_bus_pkg::*; (
  input logic     clk,
  input logic     rst,
  input bus_req_t bus_req,
  input logic     ack
);

  int fail_count = 0;  // read by the testbench top

  // stb low during reset and in the cycle after
  a_reset_quiet: assert property (@(posedge clk) $past(rst) |-> !bus_req.stb)
    else begin fail_count++; $error("stb high during or right after reset"); end

  a_req_stable: assert property (@(posedge clk) disable iff (rst)
      bus_req.stb && !ack |=> bus_req.stb && $stable(bus_req.addr) && $stable(bus_req.we))
    else begin fail_count++; $error("address or we changed while waiting for ack"); end

  a_wdata_stable: assert property (@(posedge clk) disable iff (rst)
      bus_req.stb && bus_req.we && !ack |=> $stable(bus_req.wdata))
    else begin fail_count++; $error("wdata changed while waiting for ack"); end

  // a write may be followed directly by the next fetch
  a_read_drop: assert property (@(posedge clk) disable iff (rst)
      bus_req.stb && ack && !bus_req.we |=> !bus_req.stb)
    else begin fail_count++; $error("stb still high in the cycle after a read ack"); end

  a_write_drop: assert property (@(posedge clk) disable iff (rst)
      bus_req.stb && ack && bus_req.we |=> !bus_req.we)
    else begin fail_count++; $error("write still requested in the cycle after its ack"); end

endmodule

// File: verilog/risc5_core.sv
/*
  RISC5 core top: datapath, ALU and controller on one stb/ack bus
*/
`timescale 1ns/1ps

module risc5_core import risc5_isa_pkg::*, risc5_bus_pkg::*; #(
  parameter logic [addr_w-1:0] reset_addr = '0
) (
  input  logic              clk,
  input  logic              rst,
  output bus_req_t          bus_req,
  input  logic [data_w-1:0] rdata,
  input  logic              ack
);

  ctrl_t             ctrl;
  instr_t            ir;
  flags_t            flags;
  logic [data_w-1:0] op1;
  logic [data_w-1:0] op2;
  logic [data_w-1:0] alu_res;
  logic [data_w-1:0] alu_out;
  logic              stb;
  logic              we;

  core_datapath #(
    .reset_addr (reset_addr)
  ) i_datapath (
    .clk     (clk),
    .rst     (rst),
    .ctrl    (ctrl),
    .rdata   (rdata),
    .alu_res (alu_res),
    .alu_out (alu_out),
    .ir      (ir),
    .op1     (op1),
    .op2     (op2),
    .bus_req (bus_req),
    .stb     (stb),
    .we      (we)
  );

  core_alu i_alu (
    .clk   (clk),
    .op1   (op1),
    .op2   (op2),
    .fnc   (ctrl.fnc),
    .setf  (ctrl.setf),
    .res   (alu_res),
    .out   (alu_out),
    .flags (flags)
  );

  core_ctrl i_ctrl (
    .clk   (clk),
    .rst   (rst),
    .ir    (ir),
    .ack   (ack),
    .flags (flags),
    .ctrl  (ctrl),
    .stb   (stb),
    .we    (we)
  );

endmodule

// File: verilog/core_ctrl.sv
/*
  RISC5 controller: fetch/execute FSM and branch condition evaluation
*/
`timescale 1ns/1ps

module core_ctrl import risc5_isa_pkg::*; (
  input  logic   clk,
  input  logic   rst,
  input  instr_t ir,
  input  logic   ack,
  input  flags_t flags,
  output ctrl_t  ctrl,
  output logic   stb,
  output logic   we
);

  typedef enum logic [3:0] {
    st_reset, st_fetch, st_decode, st_exec, st_wb, st_addr,
    st_load, st_load_wb, st_store, st_br_reg, st_br_rel
  } state_e;

  state_e state;
  state_e next_state;
  logic   cond;
  logic   take;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= st_reset;
    end else begin
      state <= next_state;
    end
  end

  // --------------------------------------------------
  // branch condition, a[3] inverts
  always_comb begin
    case (cond_e'(ir.a[2:0]))
      cond_mi: cond = flags.n;
      cond_eq: cond = flags.z;
      cond_cs: cond = flags.c;
      cond_vs: cond = flags.v;
      cond_ls: cond = flags.c | flags.z;
      cond_lt: cond = flags.n ^ flags.v;
      cond_le: cond = (flags.n ^ flags.v) | flags.z;
      default: cond = 1'b1;
    endcase
  end

  assign take = ir.a[3] ^ cond;

  // --------------------------------------------------
  // state outputs
  always_comb begin
    ctrl       = '0;  // a2 c, src2 four, mov
    stb        = 1'b0;
    we         = 1'b0;
    next_state = st_reset;
    case (state)
      st_reset: begin
        ctrl.pc_we = 1'b1;  // load reset vector
        next_state = st_fetch;
      end
      st_fetch: begin
        stb        = 1'b1;
        ctrl.ir_we = ack;
        next_state = ack ? st_decode : st_fetch;
      end
      st_decode: begin
        ctrl.pc_we  = 1'b1;  // pc + 4
        ctrl.pc_src = 1'b1;
        ctrl.fnc    = fnc_add;
        case (ir.pq)
          fmt_reg_reg, fmt_reg_imm: next_state = st_exec;
          fmt_memory:               next_state = st_addr;
          default:                  next_state = ir.u ? st_br_rel : st_br_reg;
        endcase
      end
      st_exec: begin
        ctrl.src1 = 1'b1;
        ctrl.fnc  = alu_fnc_e'(ir.op);
        ctrl.setf = 1'b1;
        if (ir.pq == fmt_reg_reg) begin
          ctrl.src2 = src2_reg;
        end else if (ir.op == fnc_mov && ir.u) begin
          ctrl.src2 = src2_imm_hi;
        end else begin
          ctrl.src2 = src2_imm16;
        end
        next_state = st_wb;
      end
      st_wb: begin
        ctrl.a2_src = a2_a;
        ctrl.reg_we = 1'b1;
        next_state  = st_fetch;
      end
      st_addr, st_load, st_store: begin
        // effective address kept in the alu out register
        ctrl.a2_src = a2_a;
        ctrl.src1   = 1'b1;
        ctrl.src2   = src2_off20;
        ctrl.fnc    = fnc_add;
        if (state == st_addr) begin
          next_state = ir.u ? st_store : st_load;
        end else begin
          stb           = 1'b1;
          we            = (state == st_store);
          ctrl.addr_src = 1'b1;
          if (!ack) begin
            next_state = state;
          end else begin
            next_state = (state == st_store) ? st_fetch : st_load_wb;
          end
        end
      end
      st_load_wb: begin
        ctrl.a2_src = a2_a;
        ctrl.di_src = 1'b1;
        ctrl.reg_we = 1'b1;
        next_state  = st_fetch;
      end
      st_br_reg, st_br_rel: begin
        ctrl.pc_src = 1'b1;
        ctrl.pc_we  = take;
        ctrl.a2_src = a2_link;
        ctrl.reg_we = ir.v & take;  // link gets pc + 4 from decode
        if (state == st_br_reg) begin
          ctrl.src2 = src2_reg;
          ctrl.fnc  = fnc_mov;
        end else begin
          ctrl.src2 = src2_dist24;
          ctrl.fnc  = fnc_add;
        end
        next_state = st_fetch;
      end
      default: next_state = st_reset;
    endcase
  end

endmodule

// File: verilog/core_datapath.sv
/*
  RISC5 datapath: PC, instruction and data registers, register file,
  immediate generation and operand / write-back selection
*/
`timescale 1ns/1ps

module core_datapath import risc5_isa_pkg::*, risc5_bus_pkg::*; #(
  parameter logic [addr_w-1:0] reset_addr = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  ctrl_t             ctrl,
  input  logic [data_w-1:0] rdata,
  input  logic [data_w-1:0] alu_res,
  input  logic [data_w-1:0] alu_out,
  output instr_t            ir,
  output logic [data_w-1:0] op1,
  output logic [data_w-1:0] op2,
  output bus_req_t          bus_req,
  input  logic              stb,
  input  logic              we
);

  logic [addr_w-1:0] pc;
  logic [addr_w-1:0] pc_next;
  logic [data_w-1:0] dr;
  logic [data_w-1:0] regs [num_regs];
  logic [3:0]        reg_a2;
  logic [data_w-1:0] reg_do1;
  logic [data_w-1:0] reg_do2;
  logic [data_w-1:0] reg_di2;
  logic [data_w-1:0] imm16;
  logic [data_w-1:0] off20;
  logic [data_w-1:0] dist24;
  logic [data_w-1:0] imm_hi;

  // --------------------------------------------------
  // pc, ir, dr
  assign pc_next = ctrl.pc_src ? alu_res[addr_w-1:0] : reset_addr;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= reset_addr;
    end else if (ctrl.pc_we) begin
      pc <= pc_next;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.ir_we) begin
      ir <= instr_t'(rdata);
    end
    dr <= rdata;  // only used after a load ack
  end

  // --------------------------------------------------
  // register file, port 1 reads b, port 2 reads and writes
  always_comb begin
    case (ctrl.a2_src)
      a2_c:    reg_a2 = ir.imm[3:0];
      a2_link: reg_a2 = link_reg;
      default: reg_a2 = ir.a;  // dest, store source
    endcase
  end

  assign reg_di2 = ctrl.di_src ? dr : alu_out;

  always_ff @(posedge clk) begin
    reg_do1 <= regs[ir.b];
    reg_do2 <= regs[reg_a2];
    if (ctrl.reg_we) begin
      regs[reg_a2] <= reg_di2;
    end
  end

  // --------------------------------------------------
  // operands
  assign imm16  = {{16{ir.v}}, ir.imm};
  assign off20  = {{12{ir.op[3]}}, ir.op, ir.imm};
  assign dist24 = {{6{ir.b[3]}}, ir.b, ir.op, ir.imm, 2'b00};  // word distance
  assign imm_hi = {ir.imm, 16'h0000};

  assign op1 = ctrl.src1 ? reg_do1 : {{(data_w-addr_w){1'b0}}, pc};

  always_comb begin
    case (ctrl.src2)
      src2_four:   op2 = 32'd4;
      src2_reg:    op2 = reg_do2;
      src2_imm16:  op2 = imm16;
      src2_off20:  op2 = off20;
      src2_dist24: op2 = dist24;
      src2_imm_hi: op2 = imm_hi;
      default:     op2 = '0;
    endcase
  end

  // bus request
  assign bus_req.stb   = stb;
  assign bus_req.we    = we;
  assign bus_req.addr  = ctrl.addr_src ? alu_out[addr_w-1:0] : pc;
  assign bus_req.wdata = reg_do2;

endmodule

// File: verilog/core_alu.sv
/*
  RISC5 ALU: move, shifts, logic, add and subtract with a registered
  result copy and the N/Z/C/V flag register
*/
`timescale 1ns/1ps

module core_alu import risc5_isa_pkg::*, risc5_bus_pkg::*; (
  input  logic              clk,
  input  logic [data_w-1:0] op1,
  input  logic [data_w-1:0] op2,
  input  alu_fnc_e          fnc,
  input  logic              setf,
  output logic [data_w-1:0] res,
  output logic [data_w-1:0] out,
  output flags_t            flags
);

  logic [$clog2(data_w)-1:0] shamt;
  logic [2*data_w-1:0]       ror_wide;
  logic                      known;
  logic                      x;
  logic                      y;
  logic                      z;
  flags_t                    next_flags;

  assign shamt    = op2[$clog2(data_w)-1:0];
  assign ror_wide = {op1, op1} >> shamt;  // low half is the rotate
  assign known    = (fnc <= fnc_sub);

  always_comb begin
    case (fnc)
      fnc_mov: res = op2;
      fnc_lsl: res = op1 << shamt;
      fnc_asr: res = $signed(op1) >>> shamt;
      fnc_ror: res = ror_wide[data_w-1:0];
      fnc_and: res = op1 & op2;
      fnc_ann: res = op1 & ~op2;
      fnc_ior: res = op1 | op2;
      fnc_xor: res = op1 ^ op2;
      fnc_add: res = op1 + op2;
      fnc_sub: res = op1 - op2;
      default: res = '0;  // dropped mul/div/fp codes
    endcase
  end

  always_ff @(posedge clk) begin
    out <= res;
  end

  // --------------------------------------------------
  // flags
  assign x = op1[data_w-1];
  assign y = op2[data_w-1];
  assign z = res[data_w-1];

  always_comb begin
    next_flags   = flags;  // c and v kept unless add/sub
    next_flags.n = z;
    next_flags.z = (res == '0);
    if (fnc == fnc_add) begin
      next_flags.c = (x & y) | (x & ~z) | (y & ~z);
      next_flags.v = (~x & ~y & z) | (x & y & ~z);
    end else if (fnc == fnc_sub) begin
      next_flags.c = (~x & y) | (~x & z) | (y & z);  // borrow
      next_flags.v = (~x & y & z) | (x & ~y & ~z);
    end
  end

  always_ff @(posedge clk) begin
    if (setf && known) begin
      flags <= next_flags;
    end
  end

endmodule

// File: verilog/risc5_bus_pkg.sv
/*
  RISC5 memory bus: widths and the stb/ack request word
*/
package risc5_bus_pkg;

  localparam int addr_w = 24;
  localparam int data_w = 32;

  // held steady while stb waits for ack
  typedef struct packed {
    logic              stb;
    logic              we;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
  } bus_req_t;

endpackage

// File: verilog/risc5_isa_pkg.sv
/*
  RISC5 instruction set definitions: instruction word layout, formats,
  ALU functions, operand selects, branch conditions and the control word
*/
package risc5_isa_pkg;

  localparam logic [3:0] link_reg = 4'd15;  // return address register
  localparam int         num_regs = 16;

  typedef enum logic [1:0] {
    fmt_reg_reg = 2'b00,
    fmt_reg_imm = 2'b01,
    fmt_memory  = 2'b10,
    fmt_branch  = 2'b11
  } fmt_e;

  // codes 10 to 15 are not implemented
  typedef enum logic [3:0] {
    fnc_mov = 4'h0,
    fnc_lsl = 4'h1,
    fnc_asr = 4'h2,
    fnc_ror = 4'h3,
    fnc_and = 4'h4,
    fnc_ann = 4'h5,  // and not
    fnc_ior = 4'h6,
    fnc_xor = 4'h7,
    fnc_add = 4'h8,
    fnc_sub = 4'h9
  } alu_fnc_e;

  typedef enum logic [2:0] {
    src2_four   = 3'd0,  // pc increment
    src2_reg    = 3'd1,
    src2_imm16  = 3'd2,  // sign taken from v
    src2_off20  = 3'd3,  // memory offset
    src2_dist24 = 3'd4,  // branch distance in words
    src2_imm_hi = 3'd5   // imm16 << 16
  } src2_e;

  typedef enum logic [1:0] {
    a2_c    = 2'd0,
    a2_a    = 2'd1,
    a2_link = 2'd2
  } a2_src_e;

  typedef enum logic [2:0] {
    cond_mi, cond_eq, cond_cs, cond_vs,
    cond_ls, cond_lt, cond_le, cond_always
  } cond_e;

  typedef struct packed {
    fmt_e        pq;
    logic        u;
    logic        v;
    logic [3:0]  a;
    logic [3:0]  b;
    logic [3:0]  op;
    logic [15:0] imm;  // also holds c, off and dist bits
  } instr_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // ----------------------------------------------
  // control word from the FSM
  typedef struct packed {
    logic     pc_we;
    logic     pc_src;    // 0 reset vector, 1 alu result
    logic     addr_src;  // 0 pc, 1 alu out
    logic     ir_we;
    logic     reg_we;
    a2_src_e  a2_src;
    logic     di_src;    // 0 alu out, 1 data register
    logic     src1;      // 0 pc, 1 register
    src2_e    src2;
    alu_fnc_e fnc;
    logic     setf;
  } ctrl_t;

endpackage
